/* Bender.yml */
package:
  name: smartnic_app

sources:
  - common/smartnic_app_pkg.sv
  - common/smartnic_reg_pkg.sv
  - common/axis_if.sv
  - logic/axis_pipe.sv
  - logic/axis_port_demux.sv
  - logic/axis_pkt_mux.sv
  - logic/axis_probe.sv
  - logic/smartnic_app_regs.sv
  - logic/smartnic_app.sv
  - target: test
    files:
      - tests/tb_smartnic_app.sv

/* common/axis_if.sv */
interface axis_if;

    logic                     tvalid;
    logic                     tready;
    smartnic_app_pkg::tdata_t tdata;
    smartnic_app_pkg::tkeep_t tkeep;
    logic                     tlast;
    smartnic_app_pkg::port_t  tid;
    smartnic_app_pkg::port_t  tdest;

    modport source (
        output tvalid, tdata, tkeep, tlast, tid, tdest,
        input  tready
    );

    modport sink (
        input  tvalid, tdata, tkeep, tlast, tid, tdest,
        output tready
    );

    // Passive tap for probes
    modport monitor (
        input tvalid, tready, tdata, tkeep, tlast, tid, tdest
    );

endinterface : axis_if

/* common/smartnic_app_pkg.sv */
package smartnic_app_pkg;

    // Stream geometry
    localparam int DATA_BYTE_WID = 8;
    localparam int PORT_WID      = 4;

    // Port type sits in the upper half of tid/tdest
    localparam int PORT_TYP_LSB  = 2;

    typedef logic [DATA_BYTE_WID*8-1:0] tdata_t;
    typedef logic [DATA_BYTE_WID-1:0]   tkeep_t;
    typedef logic [PORT_WID-1:0]        port_t;

    // Valid byte count of one beat from 0 to DATA_BYTE_WID
    typedef logic [3:0] byte_cnt_t;

    typedef enum logic [1:0] {
        PHY = 2'd0,
        PF  = 2'd1,
        VF  = 2'd2,
        APP = 2'd3
    } port_typ_t;

endpackage : smartnic_app_pkg

/* common/smartnic_reg_pkg.sv */
package smartnic_reg_pkg;

    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [31:0] cnt_t;

    // Register map
    localparam reg_addr_t ADDR_IGR_SEL   = 8'h00;
    localparam reg_addr_t ADDR_CLEAR     = 8'h04;
    localparam reg_addr_t ADDR_IGR_PKTS  = 8'h10;
    localparam reg_addr_t ADDR_IGR_BYTES = 8'h14;
    localparam reg_addr_t ADDR_C2H_PKTS  = 8'h18;
    localparam reg_addr_t ADDR_C2H_BYTES = 8'h1C;
    localparam reg_addr_t ADDR_EGR_PKTS  = 8'h20;
    localparam reg_addr_t ADDR_EGR_BYTES = 8'h24;

    // Fields of ADDR_IGR_SEL
    localparam int IGR_SEL_EN_BIT  = 0;
    localparam int IGR_SEL_VAL_BIT = 1;

endpackage : smartnic_reg_pkg

/* logic/axis_pipe.sv */
module axis_pipe #(
    parameter int PIPE_DEPTH_EN = 1
) (
    input  logic   core_clk,
    input  logic   rst,
    axis_if.sink   from_tx,
    axis_if.source to_rx
);

    localparam int PAYLOAD_WID = $bits(smartnic_app_pkg::tdata_t)
                               + $bits(smartnic_app_pkg::tkeep_t) + 1
                               + 2 * $bits(smartnic_app_pkg::port_t);

    generate
        if (PIPE_DEPTH_EN != 0) begin : g_pipe
            logic [PAYLOAD_WID-1:0] mem [2];
            logic                   wr_ptr;
            logic                   rd_ptr;
            logic [1:0]             count;
            logic                   push;
            logic                   pop;

            // Ready from fill level only, so the downstream ready path ends here
            assign from_tx.tready = (count != 2'd2);
            assign to_rx.tvalid   = (count != 2'd0);

            assign push = from_tx.tvalid && from_tx.tready;
            assign pop  = to_rx.tvalid && to_rx.tready;

            assign {to_rx.tdata, to_rx.tkeep, to_rx.tlast, to_rx.tid, to_rx.tdest} =
                mem[rd_ptr];

            always_ff @(posedge core_clk) begin
                if (rst) begin
                    wr_ptr <= 1'b0;
                    rd_ptr <= 1'b0;
                    count  <= 2'd0;
                end else begin
                    if (push) begin
                        wr_ptr <= !wr_ptr;
                    end
                    if (pop) begin
                        rd_ptr <= !rd_ptr;
                    end
                    count <= count + {1'b0, push} - {1'b0, pop};
                end
            end

            always_ff @(posedge core_clk) begin
                if (push) begin
                    mem[wr_ptr] <= {from_tx.tdata, from_tx.tkeep, from_tx.tlast,
                                    from_tx.tid, from_tx.tdest};
                end
            end
        end else begin : g_bypass
            // Slice disabled
            assign to_rx.tvalid   = from_tx.tvalid;
            assign to_rx.tdata    = from_tx.tdata;
            assign to_rx.tkeep    = from_tx.tkeep;
            assign to_rx.tlast    = from_tx.tlast;
            assign to_rx.tid      = from_tx.tid;
            assign to_rx.tdest    = from_tx.tdest;
            assign from_tx.tready = to_rx.tready;
        end
    endgenerate

endmodule : axis_pipe

/* logic/axis_pkt_mux.sv */
module axis_pkt_mux (
    input  logic   core_clk,
    input  logic   rst,
    axis_if.sink   in0,
    axis_if.sink   in1,
    axis_if.source out
);

    logic grant_q;
    logic locked;
    logic grant_sel;
    logic in_valid;
    logic in_last;
    logic stage_ready;
    logic take;

    // ------------------------------------------------------------
    // Arbitration
    // ------------------------------------------------------------
    // grant_q holds the input last served; between packets the
    // other input wins if it has data
    always_comb begin
        if (locked) begin
            grant_sel = grant_q;
        end else if (grant_q ? in0.tvalid : in1.tvalid) begin
            grant_sel = !grant_q;
        end else begin
            grant_sel = grant_q;
        end
    end

    assign in_valid = grant_sel ? in1.tvalid : in0.tvalid;
    assign in_last  = grant_sel ? in1.tlast : in0.tlast;

    // ------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------
    assign stage_ready = !out.tvalid || out.tready;
    assign take        = in_valid && stage_ready;

    assign in0.tready = !grant_sel && stage_ready;
    assign in1.tready = grant_sel && stage_ready;

    always_ff @(posedge core_clk) begin
        if (rst) begin
            out.tvalid <= 1'b0;
            grant_q    <= 1'b0;
            locked     <= 1'b0;
        end else begin
            if (stage_ready) begin
                out.tvalid <= in_valid;
            end
            if (take) begin
                grant_q <= grant_sel;
                locked  <= !in_last;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (take) begin
            if (grant_sel) begin
                {out.tdata, out.tkeep, out.tlast, out.tid, out.tdest} <=
                    {in1.tdata, in1.tkeep, in1.tlast, in1.tid, in1.tdest};
            end else begin
                {out.tdata, out.tkeep, out.tlast, out.tid, out.tdest} <=
                    {in0.tdata, in0.tkeep, in0.tlast, in0.tid, in0.tdest};
            end
        end
    end

endmodule : axis_pkt_mux

/* logic/axis_port_demux.sv */
module axis_port_demux (
    input  logic   core_clk,
    input  logic   rst,
    axis_if.sink   from_tx,
    axis_if.source to_app,
    axis_if.source to_host,
    input  logic   sel_override_en,
    input  logic   sel_override_val
);

    smartnic_app_pkg::port_typ_t dest_typ;
    logic                        sel_new;
    logic                        sel;
    logic                        sel_q;
    logic                        in_pkt;

    // Steering decision for a packet head where 1 picks host
    assign dest_typ = smartnic_app_pkg::port_typ_t'(
        from_tx.tdest[smartnic_app_pkg::PORT_TYP_LSB +: 2]);
    assign sel_new  = sel_override_en ? sel_override_val
                                      : (dest_typ == smartnic_app_pkg::PF);

    // Held for the rest of the packet
    assign sel = in_pkt ? sel_q : sel_new;

    assign to_app.tvalid  = from_tx.tvalid && !sel;
    assign to_host.tvalid = from_tx.tvalid && sel;
    assign from_tx.tready = sel ? to_host.tready : to_app.tready;

    assign {to_app.tdata, to_app.tkeep, to_app.tlast, to_app.tid, to_app.tdest} =
        {from_tx.tdata, from_tx.tkeep, from_tx.tlast, from_tx.tid, from_tx.tdest};
    assign {to_host.tdata, to_host.tkeep, to_host.tlast, to_host.tid, to_host.tdest} =
        {from_tx.tdata, from_tx.tkeep, from_tx.tlast, from_tx.tid, from_tx.tdest};

    always_ff @(posedge core_clk) begin
        if (rst) begin
            in_pkt <= 1'b0;
            sel_q  <= 1'b0;
        end else if (from_tx.tvalid && from_tx.tready) begin
            in_pkt <= !from_tx.tlast;
            sel_q  <= sel;
        end
    end

endmodule : axis_port_demux

/* logic/axis_probe.sv */
module axis_probe (
    input  logic                    core_clk,
    input  logic                    rst,
    axis_if.monitor                 mon,
    input  logic                    clear,
    output smartnic_reg_pkg::cnt_t  pkt_cnt,
    output smartnic_reg_pkg::cnt_t  byte_cnt
);

    logic                        xfer;
    smartnic_app_pkg::byte_cnt_t beat_bytes;

    assign xfer       = mon.tvalid && mon.tready;
    assign beat_bytes = smartnic_app_pkg::byte_cnt_t'($countones(mon.tkeep));

    // Free-running counters that wrap on overflow
    always_ff @(posedge core_clk) begin
        if (rst || clear) begin
            pkt_cnt  <= '0;
            byte_cnt <= '0;
        end else if (xfer) begin
            byte_cnt <= byte_cnt + smartnic_reg_pkg::cnt_t'(beat_bytes);
            if (mon.tlast) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
        end
    end

endmodule : axis_probe

/* logic/smartnic_app.sv */
module smartnic_app #(
    parameter int PIPE_DEPTH_EN = 1
) (
    input  logic                        core_clk,
    input  logic                        rst,

    input  logic                        app_igr_tvalid,
    output logic                        app_igr_tready,
    input  smartnic_app_pkg::tdata_t    app_igr_tdata,
    input  smartnic_app_pkg::tkeep_t    app_igr_tkeep,
    input  logic                        app_igr_tlast,
    input  smartnic_app_pkg::port_t     app_igr_tid,
    input  smartnic_app_pkg::port_t     app_igr_tdest,

    output logic                        c2h_tvalid,
    input  logic                        c2h_tready,
    output smartnic_app_pkg::tdata_t    c2h_tdata,
    output smartnic_app_pkg::tkeep_t    c2h_tkeep,
    output logic                        c2h_tlast,
    output smartnic_app_pkg::port_t     c2h_tid,
    output smartnic_app_pkg::port_t     c2h_tdest,

    input  logic                        h2c_tvalid,
    output logic                        h2c_tready,
    input  smartnic_app_pkg::tdata_t    h2c_tdata,
    input  smartnic_app_pkg::tkeep_t    h2c_tkeep,
    input  logic                        h2c_tlast,
    input  smartnic_app_pkg::port_t     h2c_tid,
    input  smartnic_app_pkg::port_t     h2c_tdest,

    output logic                        app_egr_tvalid,
    input  logic                        app_egr_tready,
    output smartnic_app_pkg::tdata_t    app_egr_tdata,
    output smartnic_app_pkg::tkeep_t    app_egr_tkeep,
    output logic                        app_egr_tlast,
    output smartnic_app_pkg::port_t     app_egr_tid,
    output smartnic_app_pkg::port_t     app_egr_tdest,

    input  logic                        reg_req_valid,
    output logic                        reg_req_ready,
    input  logic                        reg_req_write,
    input  smartnic_reg_pkg::reg_addr_t reg_req_addr,
    input  smartnic_reg_pkg::reg_data_t reg_req_wdata,
    output logic                        reg_rsp_valid,
    input  logic                        reg_rsp_ready,
    output smartnic_reg_pkg::reg_data_t reg_rsp_rdata
);

    axis_if igr_if ();
    axis_if demux_app_if ();
    axis_if demux_host_if ();
    axis_if loop_if ();
    axis_if c2h_if ();
    axis_if h2c_if ();
    axis_if egr_if ();

    logic                   sel_override_en;
    logic                   sel_override_val;
    logic                   clear;
    smartnic_reg_pkg::cnt_t igr_pkts;
    smartnic_reg_pkg::cnt_t igr_bytes;
    smartnic_reg_pkg::cnt_t c2h_pkts;
    smartnic_reg_pkg::cnt_t c2h_bytes;
    smartnic_reg_pkg::cnt_t egr_pkts;
    smartnic_reg_pkg::cnt_t egr_bytes;

    // ------------------------------------------------------------
    // Plain ports to and from interfaces
    // ------------------------------------------------------------
    assign {igr_if.tvalid, igr_if.tdata, igr_if.tkeep, igr_if.tlast, igr_if.tid, igr_if.tdest} =
        {app_igr_tvalid, app_igr_tdata, app_igr_tkeep, app_igr_tlast, app_igr_tid, app_igr_tdest};
    assign app_igr_tready = igr_if.tready;

    assign {h2c_if.tvalid, h2c_if.tdata, h2c_if.tkeep, h2c_if.tlast, h2c_if.tid, h2c_if.tdest} =
        {h2c_tvalid, h2c_tdata, h2c_tkeep, h2c_tlast, h2c_tid, h2c_tdest};
    assign h2c_tready = h2c_if.tready;

    assign {c2h_tvalid, c2h_tdata, c2h_tkeep, c2h_tlast, c2h_tid, c2h_tdest} =
        {c2h_if.tvalid, c2h_if.tdata, c2h_if.tkeep, c2h_if.tlast, c2h_if.tid, c2h_if.tdest};
    assign c2h_if.tready = c2h_tready;

    assign {app_egr_tvalid, app_egr_tdata, app_egr_tkeep, app_egr_tlast, app_egr_tid,
            app_egr_tdest} =
        {egr_if.tvalid, egr_if.tdata, egr_if.tkeep, egr_if.tlast, egr_if.tid, egr_if.tdest};
    assign egr_if.tready = app_egr_tready;

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    smartnic_app_regs smartnic_app_regs_inst (
        .core_clk, .rst,
        .reg_req_valid, .reg_req_ready, .reg_req_write, .reg_req_addr, .reg_req_wdata,
        .reg_rsp_valid, .reg_rsp_ready, .reg_rsp_rdata,
        .sel_override_en, .sel_override_val, .clear,
        .igr_pkts, .igr_bytes, .c2h_pkts, .c2h_bytes, .egr_pkts, .egr_bytes
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    axis_port_demux axis_port_demux_inst (
        .core_clk, .rst,
        .from_tx (igr_if),
        .to_app  (demux_app_if),
        .to_host (demux_host_if),
        .sel_override_en, .sel_override_val
    );

    // Application path is a plain loopback into the mux
    axis_pipe #(.PIPE_DEPTH_EN(PIPE_DEPTH_EN)) pipe_app (
        .core_clk, .rst, .from_tx(demux_app_if), .to_rx(loop_if)
    );

    axis_pipe #(.PIPE_DEPTH_EN(PIPE_DEPTH_EN)) pipe_c2h (
        .core_clk, .rst, .from_tx(demux_host_if), .to_rx(c2h_if)
    );

    axis_pkt_mux axis_pkt_mux_inst (
        .core_clk, .rst, .in0(loop_if), .in1(h2c_if), .out(egr_if)
    );

    // Probes
    axis_probe probe_igr (
        .core_clk, .rst, .mon(igr_if), .clear, .pkt_cnt(igr_pkts), .byte_cnt(igr_bytes)
    );
    axis_probe probe_c2h (
        .core_clk, .rst, .mon(c2h_if), .clear, .pkt_cnt(c2h_pkts), .byte_cnt(c2h_bytes)
    );
    axis_probe probe_egr (
        .core_clk, .rst, .mon(egr_if), .clear, .pkt_cnt(egr_pkts), .byte_cnt(egr_bytes)
    );

endmodule : smartnic_app

/* logic/smartnic_app_regs.sv */
module smartnic_app_regs (
    input  logic                        core_clk,
    input  logic                        rst,

    input  logic                        reg_req_valid,
    output logic                        reg_req_ready,
    input  logic                        reg_req_write,
    input  smartnic_reg_pkg::reg_addr_t reg_req_addr,
    input  smartnic_reg_pkg::reg_data_t reg_req_wdata,
    output logic                        reg_rsp_valid,
    input  logic                        reg_rsp_ready,
    output smartnic_reg_pkg::reg_data_t reg_rsp_rdata,

    output logic                        sel_override_en,
    output logic                        sel_override_val,
    output logic                        clear,

    input  smartnic_reg_pkg::cnt_t      igr_pkts,
    input  smartnic_reg_pkg::cnt_t      igr_bytes,
    input  smartnic_reg_pkg::cnt_t      c2h_pkts,
    input  smartnic_reg_pkg::cnt_t      c2h_bytes,
    input  smartnic_reg_pkg::cnt_t      egr_pkts,
    input  smartnic_reg_pkg::cnt_t      egr_bytes
);

    typedef enum logic {
        IDLE,
        RESP
    } state_t;

    state_t                      state;
    logic                        req_take;
    smartnic_reg_pkg::reg_data_t rd_data;

    assign reg_req_ready = (state == IDLE);
    assign reg_rsp_valid = (state == RESP);
    assign req_take      = reg_req_valid && reg_req_ready;

    // ------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (reg_req_addr)
            smartnic_reg_pkg::ADDR_IGR_SEL: begin
                rd_data[smartnic_reg_pkg::IGR_SEL_EN_BIT]  = sel_override_en;
                rd_data[smartnic_reg_pkg::IGR_SEL_VAL_BIT] = sel_override_val;
            end
            smartnic_reg_pkg::ADDR_IGR_PKTS:  rd_data = igr_pkts;
            smartnic_reg_pkg::ADDR_IGR_BYTES: rd_data = igr_bytes;
            smartnic_reg_pkg::ADDR_C2H_PKTS:  rd_data = c2h_pkts;
            smartnic_reg_pkg::ADDR_C2H_BYTES: rd_data = c2h_bytes;
            smartnic_reg_pkg::ADDR_EGR_PKTS:  rd_data = egr_pkts;
            smartnic_reg_pkg::ADDR_EGR_BYTES: rd_data = egr_bytes;
            default:                          rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------
    // Request/response FSM and control registers
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (rst) begin
            state            <= IDLE;
            sel_override_en  <= 1'b0;
            sel_override_val <= 1'b0;
            clear            <= 1'b0;
        end else begin
            clear <= 1'b0;
            case (state)
                IDLE: begin
                    if (req_take) begin
                        state <= RESP;
                        if (reg_req_write) begin
                            if (reg_req_addr == smartnic_reg_pkg::ADDR_IGR_SEL) begin
                                sel_override_en  <= reg_req_wdata[smartnic_reg_pkg::IGR_SEL_EN_BIT];
                                sel_override_val <= reg_req_wdata[smartnic_reg_pkg::IGR_SEL_VAL_BIT];
                            end
                            clear <= (reg_req_addr == smartnic_reg_pkg::ADDR_CLEAR);
                        end
                    end
                end
                RESP: begin
                    if (reg_rsp_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Response data, held until taken; writes answer with 0
    always_ff @(posedge core_clk) begin
        if (req_take) begin
            reg_rsp_rdata <= reg_req_write ? '0 : rd_data;
        end
    end

endmodule : smartnic_app_regs

/* project.f */
common/smartnic_app_pkg.sv
common/smartnic_reg_pkg.sv
common/axis_if.sv
logic/axis_pipe.sv
logic/axis_port_demux.sv
logic/axis_pkt_mux.sv
logic/axis_probe.sv
logic/smartnic_app_regs.sv
logic/smartnic_app.sv
tests/tb_smartnic_app.sv

/* tests/tb_smartnic_app.sv */
module tb_smartnic_app;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PKTS = 21;
    localparam logic SRC_IGR = 1'b0;
    localparam logic SRC_H2C = 1'b1;
    localparam int DEST_C2H = 0;
    localparam int DEST_EGR = 1;
    localparam logic [7:0] TAG_IGR = 8'hA0;
    localparam logic [7:0] TAG_H2C = 8'hB1;

    typedef struct packed {
        logic [2:0] test;
        logic       src;
        logic [3:0] tdest;
        logic [3:0] len;
        logic [7:0] keep;
    } pkt_t;

    typedef struct packed {
        logic [63:0] tdata;
        logic [7:0]  tkeep;
        logic        tlast;
        logic [3:0]  tid;
        logic [3:0]  tdest;
    } beat_t;

    // test, source, tdest, beats, last-beat tkeep
    pkt_t tbl [NUM_PKTS] = '{
        '{3'd1, SRC_IGR, 4'h4, 4'd3, 8'h0F}, '{3'd1, SRC_IGR, 4'h0, 4'd2, 8'hFF},
        '{3'd1, SRC_IGR, 4'h5, 4'd1, 8'h01}, '{3'd1, SRC_IGR, 4'h9, 4'd4, 8'h3F},
        '{3'd1, SRC_IGR, 4'hC, 4'd2, 8'h07}, '{3'd1, SRC_IGR, 4'h6, 4'd5, 8'h7F},
        '{3'd2, SRC_IGR, 4'h0, 4'd2, 8'h03}, '{3'd2, SRC_IGR, 4'h8, 4'd3, 8'hFF},
        '{3'd2, SRC_IGR, 4'h4, 4'd1, 8'h1F},
        '{3'd3, SRC_IGR, 4'h4, 4'd2, 8'h0F}, '{3'd3, SRC_IGR, 4'h5, 4'd3, 8'h01},
        '{3'd3, SRC_IGR, 4'hD, 4'd1, 8'hFF},
        '{3'd4, SRC_IGR, 4'h7, 4'd2, 8'h3F}, '{3'd4, SRC_IGR, 4'h1, 4'd3, 8'h07},
        '{3'd5, SRC_IGR, 4'h0, 4'd3, 8'hFF}, '{3'd5, SRC_H2C, 4'h1, 4'd2, 8'h0F},
        '{3'd5, SRC_IGR, 4'hC, 4'd4, 8'h01}, '{3'd5, SRC_H2C, 4'h2, 4'd1, 8'h7F},
        '{3'd5, SRC_IGR, 4'h4, 4'd2, 8'h03}, '{3'd5, SRC_H2C, 4'h3, 4'd5, 8'hFF},
        '{3'd5, SRC_IGR, 4'h8, 4'd2, 8'h1F}
    };

    // Counter registers in the order igr, c2h, egr with packets before bytes
    smartnic_reg_pkg::reg_addr_t cnt_addr [6] = '{
        smartnic_reg_pkg::ADDR_IGR_PKTS, smartnic_reg_pkg::ADDR_IGR_BYTES,
        smartnic_reg_pkg::ADDR_C2H_PKTS, smartnic_reg_pkg::ADDR_C2H_BYTES,
        smartnic_reg_pkg::ADDR_EGR_PKTS, smartnic_reg_pkg::ADDR_EGR_BYTES
    };
    string cnt_name [6] = '{"IGR_PKTS", "IGR_BYTES", "C2H_PKTS", "C2H_BYTES",
                            "EGR_PKTS", "EGR_BYTES"};
    smartnic_reg_pkg::cnt_t model_cnt [6];

    logic                        core_clk = 1'b0;
    logic                        rst;
    logic                        app_igr_tvalid, app_igr_tready, app_igr_tlast;
    logic [63:0]                 app_igr_tdata;
    logic [7:0]                  app_igr_tkeep;
    logic [3:0]                  app_igr_tid, app_igr_tdest;
    logic                        c2h_tvalid, c2h_tready, c2h_tlast;
    logic [63:0]                 c2h_tdata;
    logic [7:0]                  c2h_tkeep;
    logic [3:0]                  c2h_tid, c2h_tdest;
    logic                        h2c_tvalid, h2c_tready, h2c_tlast;
    logic [63:0]                 h2c_tdata;
    logic [7:0]                  h2c_tkeep;
    logic [3:0]                  h2c_tid, h2c_tdest;
    logic                        app_egr_tvalid, app_egr_tready, app_egr_tlast;
    logic [63:0]                 app_egr_tdata;
    logic [7:0]                  app_egr_tkeep;
    logic [3:0]                  app_egr_tid, app_egr_tdest;
    logic                        reg_req_valid, reg_req_ready, reg_req_write;
    smartnic_reg_pkg::reg_addr_t reg_req_addr;
    smartnic_reg_pkg::reg_data_t reg_req_wdata;
    logic                        reg_rsp_valid, reg_rsp_ready;
    smartnic_reg_pkg::reg_data_t reg_rsp_rdata;

    beat_t       c2h_q [$];
    beat_t       egr_igr_q [$];
    beat_t       egr_h2c_q [$];
    integer      seed = 32'hc8df;
    logic [31:0] rnd;
    logic        ovr_en;
    logic        ovr_val;
    logic        egr_in_pkt;
    logic        egr_cur_h2c;
    int          err_cnt;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;

    smartnic_app #(.PIPE_DEPTH_EN(1)) smartnic_app_inst (.*);

    initial begin
        forever #50 core_clk = ~core_clk;
    end

    // Receivers are ready about three cycles in four
    always @(negedge core_clk) begin
        rnd = $random(seed);
        c2h_tready     = (rnd[1:0] != 2'b00);
        app_egr_tready = (rnd[3:2] != 2'b00);
    end

    // ----------------------------------------------------------
    // Checking helpers
    // ----------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_beat(input string port, input beat_t got, input beat_t exp);
        check_value({port, "_tdata"}, got.tdata, exp.tdata);
        check_value({port, "_tkeep"}, 64'(got.tkeep), 64'(exp.tkeep));
        check_value({port, "_tlast"}, 64'(got.tlast), 64'(exp.tlast));
        check_value({port, "_tid"}, 64'(got.tid), 64'(exp.tid));
        check_value({port, "_tdest"}, 64'(got.tdest), 64'(exp.tdest));
    endtask

    always @(posedge core_clk) begin
        if (!rst && c2h_tvalid && c2h_tready) begin
            if (c2h_q.size() == 0) begin
                $display("Unexpected beat on c2h with no packet outstanding");
                err_cnt++;
            end else begin
                compare_beat("c2h", {c2h_tdata, c2h_tkeep, c2h_tlast, c2h_tid, c2h_tdest},
                             c2h_q.pop_front());
            end
        end
    end

    always @(posedge core_clk) begin : egr_monitor
        beat_t got;
        logic  from_h2c;
        if (rst) begin
            egr_in_pkt = 1'b0;
        end else if (app_egr_tvalid && app_egr_tready) begin
            got = {app_egr_tdata, app_egr_tkeep, app_egr_tlast, app_egr_tid, app_egr_tdest};
            from_h2c = (got.tdata[63:56] == TAG_H2C);
            if (egr_in_pkt && from_h2c != egr_cur_h2c) begin
                $display("Beats of two packets interleaved on app_egr");
                err_cnt++;
            end
            egr_in_pkt  = !got.tlast;
            egr_cur_h2c = from_h2c;
            if (from_h2c ? egr_h2c_q.size() == 0 : egr_igr_q.size() == 0) begin
                $display("Unexpected beat on app_egr with no packet outstanding");
                err_cnt++;
            end else if (from_h2c) begin
                compare_beat("app_egr", got, egr_h2c_q.pop_front());
            end else begin
                compare_beat("app_egr", got, egr_igr_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    function automatic int expected_dest(input int idx);
        if (tbl[idx].src == SRC_H2C) begin
            return DEST_EGR;
        end
        if (ovr_en) begin
            return ovr_val ? DEST_C2H : DEST_EGR;
        end
        // Port type PF sits in tdest[3:2] as 1
        return (tbl[idx].tdest[3:2] == 2'd1) ? DEST_C2H : DEST_EGR;
    endfunction

    function automatic beat_t make_beat(input int idx, input int n);
        beat_t b;
        logic  last;
        last    = (n == int'(tbl[idx].len) - 1);
        b.tdata = {(tbl[idx].src ? TAG_H2C : TAG_IGR), 8'(idx), 16'(n),
                   16'(idx * 97 + n), 16'hbeef ^ 16'(n << 4)};
        b.tkeep = last ? tbl[idx].keep : 8'hFF;
        b.tlast = last;
        b.tid   = tbl[idx].src ? 4'h4 : 4'h0;
        b.tdest = tbl[idx].tdest;
        return b;
    endfunction

    task automatic send_packet(input int idx);
        beat_t b;
        int    dest;
        int    n;
        int    bytes;
        dest  = expected_dest(idx);
        bytes = (int'(tbl[idx].len) - 1) * 8 + $countones(tbl[idx].keep);
        if (tbl[idx].src == SRC_IGR) begin
            model_cnt[0]++;
            model_cnt[1] += bytes;
        end
        model_cnt[dest == DEST_C2H ? 2 : 4]++;
        model_cnt[dest == DEST_C2H ? 3 : 5] += bytes;
        for (n = 0; n < int'(tbl[idx].len); n++) begin
            b = make_beat(idx, n);
            if (dest == DEST_C2H) begin
                c2h_q.push_back(b);
            end else if (tbl[idx].src == SRC_H2C) begin
                egr_h2c_q.push_back(b);
            end else begin
                egr_igr_q.push_back(b);
            end
            @(negedge core_clk);
            if (tbl[idx].src == SRC_IGR) begin
                app_igr_tvalid = 1'b1;
                {app_igr_tdata, app_igr_tkeep, app_igr_tlast, app_igr_tid, app_igr_tdest} = b;
                @(posedge core_clk);
                while (!app_igr_tready) @(posedge core_clk);
            end else begin
                h2c_tvalid = 1'b1;
                {h2c_tdata, h2c_tkeep, h2c_tlast, h2c_tid, h2c_tdest} = b;
                @(posedge core_clk);
                while (!h2c_tready) @(posedge core_clk);
            end
        end
    endtask

    task automatic send_source(input int t, input logic src);
        int i;
        for (i = 0; i < NUM_PKTS; i++) begin
            if (tbl[i].test == t && tbl[i].src == src) begin
                send_packet(i);
            end
        end
        @(negedge core_clk);
        if (src == SRC_IGR) begin
            app_igr_tvalid = 1'b0;
        end else begin
            h2c_tvalid = 1'b0;
        end
    endtask

    task automatic run_phase(input int t);
        fork
            send_source(t, SRC_IGR);
            send_source(t, SRC_H2C);
        join
        while (c2h_q.size() != 0 || egr_igr_q.size() != 0 || egr_h2c_q.size() != 0) begin
            @(posedge core_clk);
        end
        // Catch stray beats
        repeat (8) @(posedge core_clk);
    endtask

    // ----------------------------------------------------------
    // Register port
    // ----------------------------------------------------------
    task automatic reg_access(input logic write, input smartnic_reg_pkg::reg_addr_t addr,
                              input smartnic_reg_pkg::reg_data_t wdata,
                              output smartnic_reg_pkg::reg_data_t rdata);
        @(negedge core_clk);
        reg_req_valid = 1'b1;
        reg_req_write = write;
        reg_req_addr  = addr;
        reg_req_wdata = wdata;
        @(posedge core_clk);
        while (!reg_req_ready) @(posedge core_clk);
        @(negedge core_clk);
        reg_req_valid = 1'b0;
        @(posedge core_clk);
        while (!reg_rsp_valid) @(posedge core_clk);
        rdata = reg_rsp_rdata;
    endtask

    task automatic check_reg(input smartnic_reg_pkg::reg_addr_t addr, input logic [31:0] exp,
                             input string name);
        smartnic_reg_pkg::reg_data_t rd;
        reg_access(1'b0, addr, '0, rd);
        check_value({"reg_rsp_rdata ", name}, 64'(rd), 64'(exp));
    endtask

    task automatic write_reg(input smartnic_reg_pkg::reg_addr_t addr,
                             input smartnic_reg_pkg::reg_data_t wdata);
        smartnic_reg_pkg::reg_data_t rd;
        reg_access(1'b1, addr, wdata, rd);
        check_value("reg_rsp_rdata write response", 64'(rd), 64'h0);
    endtask

    task automatic set_override(input logic en, input logic val);
        write_reg(smartnic_reg_pkg::ADDR_IGR_SEL, {30'b0, val, en});
        ovr_en  = en;
        ovr_val = val;
        check_reg(smartnic_reg_pkg::ADDR_IGR_SEL, {30'b0, val, en}, "IGR_SEL");
    endtask

    task automatic check_counters();
        int i;
        for (i = 0; i < 6; i++) begin
            check_reg(cnt_addr[i], model_cnt[i], cnt_name[i]);
        end
    endtask

    task automatic begin_test();
        test_err_start = err_cnt;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_cnt == test_err_start) begin
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_cnt - test_err_start);
        end
    endtask

    // ----------------------------------------------------------
    // Watchdog of 20 cycles per table beat
    // ----------------------------------------------------------
    initial begin : watchdog
        longint total_beats;
        longint limit_ns;
        total_beats = 0;
        foreach (tbl[i]) total_beats += tbl[i].len;
        limit_ns = total_beats * 20 * 100;
        #(limit_ns);
        $display("Timeout after %0d ns, the run did not finish", limit_ns);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        {app_igr_tvalid, app_igr_tdata, app_igr_tkeep, app_igr_tlast} = '0;
        {app_igr_tid, app_igr_tdest} = '0;
        {h2c_tvalid, h2c_tdata, h2c_tkeep, h2c_tlast, h2c_tid, h2c_tdest} = '0;
        c2h_tready     = 1'b0;
        app_egr_tready = 1'b0;
        {reg_req_valid, reg_req_write, reg_req_addr, reg_req_wdata} = '0;
        reg_rsp_ready  = 1'b1;
        {ovr_en, ovr_val, egr_in_pkt, egr_cur_h2c} = '0;
        foreach (model_cnt[i]) model_cnt[i] = '0;
        {err_cnt, tests_run, tests_failed} = '0;
        repeat (4) @(posedge core_clk);
        @(negedge core_clk);
        rst = 1'b0;

        begin_test();
        check_value("c2h_tvalid", 64'(c2h_tvalid), 64'h0);
        check_value("app_egr_tvalid", 64'(app_egr_tvalid), 64'h0);
        check_value("reg_rsp_valid", 64'(reg_rsp_valid), 64'h0);
        check_value("reg_req_ready", 64'(reg_req_ready), 64'h1);
        check_reg(smartnic_reg_pkg::ADDR_IGR_SEL, 32'h0, "IGR_SEL");
        check_counters();
        end_test("reset");

        begin_test();
        run_phase(1);
        end_test("routing");
        begin_test();
        set_override(1'b1, 1'b1);
        run_phase(2);
        end_test("override to host");
        begin_test();
        set_override(1'b1, 1'b0);
        run_phase(3);
        end_test("override to app");
        begin_test();
        set_override(1'b0, 1'b0);
        run_phase(4);
        end_test("routing resumed");
        begin_test();
        run_phase(5);
        end_test("merge");

        begin_test();
        check_counters();
        check_reg(8'h08, 32'h0, "unmapped 0x08");
        check_reg(8'h30, 32'h0, "unmapped 0x30");
        end_test("counters");

        begin_test();
        write_reg(smartnic_reg_pkg::ADDR_CLEAR, 32'h1);
        foreach (model_cnt[i]) model_cnt[i] = '0;
        check_counters();
        end_test("clear");

        $display("tests run %0d, failing tests %0d, errors %0d", tests_run, tests_failed,
                 err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_smartnic_app
